// File: core_ctrl.sv
/*
 * core controller
 * main control of the in-order core, between the decoder, the
 * fetch unit and the CSR file
 */

`default_nettype none

module core_ctrl (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic                                fetch_enable_i,
    output logic                                ctrl_busy_o,
    output logic                                first_fetch_o,

    // decoder
    input  logic                                illegal_insn_i,
    input  logic                                ecall_insn_i,
    input  logic                                ebrk_insn_i,
    input  logic                                mret_insn_i,
    input  logic                                wfi_insn_i,
    input  logic                                csr_status_i,

    // IF-ID stage
    input  logic                                instr_valid_i,
    input  logic [core_ctrl_pkg::xlen-1:0]      instr_i,
    input  logic [core_ctrl_pkg::cinsn_w-1:0]   instr_compressed_i,
    input  logic                                instr_is_compressed_i,
    output logic                                instr_valid_clear_o,
    output logic                                id_in_ready_o,

    // fetch
    output logic                                instr_req_o,
    output logic                                pc_set_o,
    output core_ctrl_pkg::pc_sel_e              pc_mux_o,
    output core_ctrl_pkg::exc_pc_sel_e          exc_pc_mux_o,

    // LSU
    input  logic [core_ctrl_pkg::xlen-1:0]      lsu_addr_last_i,
    input  logic                                load_err_i,
    input  logic                                store_err_i,

    input  logic                                branch_set_i,
    input  logic                                jump_set_i,

    // interrupts
    input  logic                                irq_i,
    input  logic                                irq_req_ctrl_i,
    input  logic [core_ctrl_pkg::irq_id_w-1:0]  irq_id_ctrl_i,
    input  logic                                m_ie_i,
    output logic                                irq_ack_o,
    output logic [core_ctrl_pkg::irq_id_w-1:0]  irq_id_o,

    output core_ctrl_pkg::exc_cause_u           exc_cause_o,
    output logic                                exc_ack_o,

    // CSR file
    output logic                                csr_save_if_o,
    output logic                                csr_save_id_o,
    output logic                                csr_restore_mret_o,
    output logic                                csr_save_cause_o,
    output logic [core_ctrl_pkg::xlen-1:0]      csr_mtval_o,

    // stall sources
    input  logic                                stall_lsu_i,
    input  logic                                stall_multdiv_i,
    input  logic                                stall_jump_i,
    input  logic                                stall_branch_i
);

  logic stall;
  logic special_req;
  logic trap_pend;
  logic handle_irq;
  logic load_err_q;
  logic store_err_q;
  logic trap_take;
  logic irq_take;

  // acked id always follows the interrupt controller
  assign irq_id_o = irq_id_ctrl_i;

  ctrl_req_decode u_req_decode (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .illegal_insn_i  (illegal_insn_i),
    .ecall_insn_i    (ecall_insn_i),
    .ebrk_insn_i     (ebrk_insn_i),
    .mret_insn_i     (mret_insn_i),
    .wfi_insn_i      (wfi_insn_i),
    .csr_status_i    (csr_status_i),
    .load_err_i      (load_err_i),
    .store_err_i     (store_err_i),
    .stall_lsu_i     (stall_lsu_i),
    .stall_multdiv_i (stall_multdiv_i),
    .stall_jump_i    (stall_jump_i),
    .stall_branch_i  (stall_branch_i),
    .irq_req_ctrl_i  (irq_req_ctrl_i),
    .m_ie_i          (m_ie_i),
    .stall_o         (stall),
    .special_req_o   (special_req),
    .trap_pend_o     (trap_pend),
    .handle_irq_o    (handle_irq),
    .load_err_q_o    (load_err_q),
    .store_err_q_o   (store_err_q)
  );

  ctrl_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .instr_valid_i       (instr_valid_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .mret_insn_i         (mret_insn_i),
    .wfi_insn_i          (wfi_insn_i),
    .irq_i               (irq_i),
    .stall_i             (stall),
    .special_req_i       (special_req),
    .trap_pend_i         (trap_pend),
    .handle_irq_i        (handle_irq),
    .ctrl_busy_o         (ctrl_busy_o),
    .first_fetch_o       (first_fetch_o),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .irq_ack_o           (irq_ack_o),
    .exc_ack_o           (exc_ack_o),
    .csr_save_if_o       (csr_save_if_o),
    .csr_save_id_o       (csr_save_id_o),
    .csr_save_cause_o    (csr_save_cause_o),
    .csr_restore_mret_o  (csr_restore_mret_o),
    .trap_take_o         (trap_take),
    .irq_take_o          (irq_take)
  );

  ctrl_trap_result u_trap_result (
    .trap_take_i           (trap_take),
    .irq_take_i            (irq_take),
    .illegal_insn_i        (illegal_insn_i),
    .ecall_insn_i          (ecall_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .instr_is_compressed_i (instr_is_compressed_i),
    .instr_i               (instr_i),
    .instr_compressed_i    (instr_compressed_i),
    .load_err_q_i          (load_err_q),
    .store_err_q_i         (store_err_q),
    .lsu_addr_last_i       (lsu_addr_last_i),
    .irq_id_ctrl_i         (irq_id_ctrl_i),
    .exc_cause_o           (exc_cause_o),
    .csr_mtval_o           (csr_mtval_o)
  );

endmodule

`default_nettype wire

// File: core_ctrl_asserts.sv
/*
 * core controller assertions
 * port level rules on fetch redirect, interrupt ack and CSR save
 */

`default_nettype none

module core_ctrl_asserts (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    pc_set_i,
    input  logic                    instr_req_i,
    input  logic                    ctrl_busy_i,
    input  core_ctrl_pkg::pc_sel_e  pc_mux_i,
    input  logic                    irq_ack_i,
    input  logic                    exc_ack_i,
    input  logic                    csr_save_id_i,
    input  logic                    csr_save_if_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import core_ctrl_pkg::*;

  // redirect without a fetch request only while boot address is held
  boot_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (pc_set_i && !instr_req_i) |-> (pc_mux_i == PC_BOOT && ctrl_busy_i))
    else $error("pc set without instr request outside reset state");

  irq_ack_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
      irq_ack_i |-> exc_ack_i)
    else $error("irq ack without exc ack");

  // one pc source for mepc per cycle
  save_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(csr_save_id_i && csr_save_if_i))
    else $error("csr save from IF and ID in the same cycle");

endmodule

bind core_ctrl core_ctrl_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .pc_set_i      (pc_set_o),
  .instr_req_i   (instr_req_o),
  .ctrl_busy_i   (ctrl_busy_o),
  .pc_mux_i      (pc_mux_o),
  .irq_ack_i     (irq_ack_o),
  .exc_ack_i     (exc_ack_o),
  .csr_save_id_i (csr_save_id_o),
  .csr_save_if_i (csr_save_if_o)
);

`default_nettype wire

// File: core_ctrl_pkg.sv
/*
 * core controller package
 * widths, fetch address selectors, synchronous exception codes
 * and the trap cause word shared by the controller blocks
 */

`default_nettype none

package core_ctrl_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // data and address width
  localparam int unsigned xlen     = 32;
  // compressed instruction width
  localparam int unsigned cinsn_w  = 16;
  // interrupt identifier width
  localparam int unsigned irq_id_w = 5;
  // trap cause word, irq flag plus id
  localparam int unsigned cause_w  = 6;

  ////////////////////////////////////////
  // fetch selectors
  ////////////////////////////////////////

  // fetch address source for the prefetcher
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_EXC  = 2'd2,
    PC_ERET = 2'd3
  } pc_sel_e;

  // trap vector when pc_mux is PC_EXC
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  ////////////////////////////////////////
  // trap cause
  ////////////////////////////////////////

  // synchronous exception codes, mcause numbering
  typedef enum logic [cause_w-1:0] {
    EXC_CAUSE_NONE               = 6'd0,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'd5,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'd7,
    EXC_CAUSE_ECALL_MMODE        = 6'd11
  } exc_code_e;

  // interrupt view, msb flags an interrupt
  typedef struct packed {
    logic                irq;
    logic [irq_id_w-1:0] id;
  } irq_cause_t;

  // one cause word, read as exception code or as interrupt
  typedef union packed {
    exc_code_e  exc;
    irq_cause_t irq;
  } exc_cause_u;

endpackage

`default_nettype wire

// File: ctrl_fsm.sv
/*
 * controller FSM
 * sequences boot, redirects fetch on jumps, branches, traps and
 * mret, handles wfi sleep and interrupt entry, and gates the
 * IF-ID stage through the halt and stall levels
 */

`default_nettype none

module ctrl_fsm (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        fetch_enable_i,
    input  logic                        instr_valid_i,
    input  logic                        branch_set_i,
    input  logic                        jump_set_i,
    input  logic                        mret_insn_i,
    input  logic                        wfi_insn_i,
    input  logic                        irq_i,

    // merged requests
    input  logic                        stall_i,
    input  logic                        special_req_i,
    input  logic                        trap_pend_i,
    input  logic                        handle_irq_i,

    output logic                        ctrl_busy_o,
    output logic                        first_fetch_o,
    output logic                        instr_req_o,
    output logic                        pc_set_o,
    output core_ctrl_pkg::pc_sel_e      pc_mux_o,
    output core_ctrl_pkg::exc_pc_sel_e  exc_pc_mux_o,
    output logic                        id_in_ready_o,
    output logic                        instr_valid_clear_o,
    output logic                        irq_ack_o,
    output logic                        exc_ack_o,
    output logic                        csr_save_if_o,
    output logic                        csr_save_id_o,
    output logic                        csr_save_cause_o,
    output logic                        csr_restore_mret_o,
    output logic                        trap_take_o,
    output logic                        irq_take_o
);
  import core_ctrl_pkg::*;

  typedef enum logic [2:0] {
    RESET, BOOT_SET, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN, WAIT_SLEEP, SLEEP
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;

  logic halt_if;
  logic halt_id;

  ////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    ctrl_busy_o        = 1'b1;
    first_fetch_o      = 1'b0;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    halt_if            = 1'b0;
    halt_id            = 1'b0;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    trap_take_o        = 1'b0;
    irq_take_o         = 1'b0;

    unique case (state_q)
      RESET: begin
        // hold boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        // pipeline is empty here, so irq can go straight in
        if (handle_irq_i) begin
          halt_if = 1'b1;
          halt_id = 1'b1;
          state_d = IRQ_TAKEN;
        end else if (!stall_i) begin
          state_d = DECODE;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          if (branch_set_i || jump_set_i) begin
            // redirect fetch to the target, same cycle
            pc_mux_o = PC_JUMP;
            pc_set_o = 1'b1;
          end else if (special_req_i) begin
            halt_if = 1'b1;
            halt_id = 1'b1;
            state_d = FLUSH;
          end
        end
        // keep new instrs out while the multicycle instr finishes
        if (handle_irq_i && stall_i) begin
          halt_if = 1'b1;
        end
        if (handle_irq_i && !stall_i && !special_req_i) begin
          halt_if = 1'b1;
          halt_id = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end

      FLUSH: begin
        halt_if = 1'b1;
        halt_id = 1'b1;
        state_d = DECODE;
        if (trap_pend_i) begin
          // save pc of the faulting instr in ID
          pc_mux_o         = PC_EXC;
          pc_set_o         = 1'b1;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          trap_take_o      = 1'b1;
        end else if (mret_insn_i) begin
          pc_mux_o           = PC_ERET;
          pc_set_o           = 1'b1;
          csr_restore_mret_o = 1'b1;
        end else if (wfi_insn_i) begin
          state_d = WAIT_SLEEP;
        end
      end

      IRQ_TAKEN: begin
        // save pc of the next instr in IF
        pc_mux_o         = PC_EXC;
        pc_set_o         = 1'b1;
        exc_pc_mux_o     = EXC_PC_IRQ;
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
        irq_take_o       = 1'b1;
        state_d          = DECODE;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        // wake on any irq line, taken or not
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        if (irq_i) begin
          state_d = FIRST_FETCH;
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // IF-ID gating
  ////////////////////////////////////////

  assign id_in_ready_o       = ~stall_i & ~halt_if;
  // drop finished instrs, or killed ones on a halt
  assign instr_valid_clear_o = ~stall_i | halt_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: ctrl_req_decode.sv
/*
 * controller request decode
 * merges decoder flags, stall sources and the interrupt enable
 * into the requests seen by the FSM, and keeps a one cycle copy
 * of the LSU access faults for the flush cycle
 */

`default_nettype none

module ctrl_req_decode (
    input  logic clk_i,
    input  logic rst_ni,

    // decoder flags
    input  logic illegal_insn_i,
    input  logic ecall_insn_i,
    input  logic ebrk_insn_i,
    input  logic mret_insn_i,
    input  logic wfi_insn_i,
    input  logic csr_status_i,

    // LSU fault pulses
    input  logic load_err_i,
    input  logic store_err_i,

    // multicycle stall sources
    input  logic stall_lsu_i,
    input  logic stall_multdiv_i,
    input  logic stall_jump_i,
    input  logic stall_branch_i,

    // interrupt controller
    input  logic irq_req_ctrl_i,
    input  logic m_ie_i,

    output logic stall_o,
    output logic special_req_o,
    output logic trap_pend_o,
    output logic handle_irq_o,
    output logic load_err_q_o,
    output logic store_err_q_o
);

  logic exc_req;
  logic exc_req_lsu;
  logic load_err_q;
  logic store_err_q;

  // instruction exceptions, ebreak always traps
  assign exc_req     = illegal_insn_i | ecall_insn_i | ebrk_insn_i;
  // lsu faults only last one cycle
  assign exc_req_lsu = load_err_i | store_err_i;

  // anything that needs the pipeline flushed
  assign special_req_o = mret_insn_i | wfi_insn_i | csr_status_i | exc_req | exc_req_lsu;

  // in FLUSH the raw fault is gone, so use the registered copy
  assign trap_pend_o = exc_req | load_err_q | store_err_q;

  // current instr still needs cycles after this one
  assign stall_o = stall_lsu_i | stall_multdiv_i | stall_jump_i | stall_branch_i;

  // machine interrupts only when globally enabled
  assign handle_irq_o = irq_req_ctrl_i & m_ie_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      load_err_q  <= load_err_i;
      store_err_q <= store_err_i;
    end
  end

  assign load_err_q_o  = load_err_q;
  assign store_err_q_o = store_err_q;

endmodule

`default_nettype wire

// File: ctrl_trap_result.sv
/*
 * trap result
 * picks the cause word and mtval for the cycle in which the
 * FSM takes a synchronous trap or an interrupt
 */

`default_nettype none

module ctrl_trap_result (
    input  logic                                trap_take_i,
    input  logic                                irq_take_i,

    // decoder flags and the instr in ID
    input  logic                                illegal_insn_i,
    input  logic                                ecall_insn_i,
    input  logic                                ebrk_insn_i,
    input  logic                                instr_is_compressed_i,
    input  logic [core_ctrl_pkg::xlen-1:0]      instr_i,
    input  logic [core_ctrl_pkg::cinsn_w-1:0]   instr_compressed_i,

    // registered LSU faults and their address
    input  logic                                load_err_q_i,
    input  logic                                store_err_q_i,
    input  logic [core_ctrl_pkg::xlen-1:0]      lsu_addr_last_i,

    input  logic [core_ctrl_pkg::irq_id_w-1:0]  irq_id_ctrl_i,

    output core_ctrl_pkg::exc_cause_u           exc_cause_o,
    output logic [core_ctrl_pkg::xlen-1:0]      csr_mtval_o
);
  import core_ctrl_pkg::*;

  always_comb begin
    exc_cause_o.exc = EXC_CAUSE_NONE;
    csr_mtval_o     = '0;

    if (irq_take_i) begin
      exc_cause_o.irq.irq = 1'b1;
      exc_cause_o.irq.id  = irq_id_ctrl_i;
    end else if (trap_take_i) begin
      // priority as in the privileged spec, instr faults first
      if (illegal_insn_i) begin
        exc_cause_o.exc = EXC_CAUSE_ILLEGAL_INSN;
        csr_mtval_o     = instr_is_compressed_i ?
                          {{(xlen-cinsn_w){1'b0}}, instr_compressed_i} : instr_i;
      end else if (ecall_insn_i) begin
        exc_cause_o.exc = EXC_CAUSE_ECALL_MMODE;
      end else if (ebrk_insn_i) begin
        exc_cause_o.exc = EXC_CAUSE_BREAKPOINT;
      end else if (store_err_q_i) begin
        exc_cause_o.exc = EXC_CAUSE_STORE_ACCESS_FAULT;
        csr_mtval_o     = lsu_addr_last_i;
      end else if (load_err_q_i) begin
        exc_cause_o.exc = EXC_CAUSE_LOAD_ACCESS_FAULT;
        csr_mtval_o     = lsu_addr_last_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the core controller testbench with Verilator
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module tb_core_ctrl -f vlog.f \
    && ./obj_dir/Vtb_core_ctrl; } > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// File: tb_core_ctrl.sv
/*
 * core controller testbench
 * random stimulus from a fixed seed, checked every cycle against
 * a cycle model of the controller FSM and the trap result rules
 */

`default_nettype none

module tb_core_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import core_ctrl_pkg::*;

  typedef enum int {
    S_RESET, S_BOOT_SET, S_FIRST_FETCH, S_DECODE, S_FLUSH, S_IRQ_TAKEN, S_WAIT_SLEEP, S_SLEEP
  } model_state_e;

  // DUT inputs
  logic clk_i, rst_ni, fetch_enable_i;
  logic illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, wfi_insn_i, csr_status_i;
  logic instr_valid_i, instr_is_compressed_i, branch_set_i, jump_set_i;
  logic [xlen-1:0] instr_i, lsu_addr_last_i;
  logic [cinsn_w-1:0] instr_compressed_i;
  logic load_err_i, store_err_i, irq_i, irq_req_ctrl_i, m_ie_i;
  logic [irq_id_w-1:0] irq_id_ctrl_i;
  logic stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i;

  // DUT outputs
  logic ctrl_busy_o, first_fetch_o, instr_valid_clear_o, id_in_ready_o, instr_req_o, pc_set_o;
  pc_sel_e pc_mux_o;
  exc_pc_sel_e exc_pc_mux_o;
  logic irq_ack_o, exc_ack_o, csr_save_if_o, csr_save_id_o, csr_restore_mret_o, csr_save_cause_o;
  logic [irq_id_w-1:0] irq_id_o;
  exc_cause_u exc_cause_o;
  logic [xlen-1:0] csr_mtval_o;
  logic [cause_w-1:0] cause_bits;

  // model registers and expected outputs
  model_state_e m_state, m_state_d;
  logic m_load_q, m_store_q, m_load_d, m_store_d;
  logic e_busy, e_first, e_req, e_set, e_ready, e_clear;
  logic e_irq_ack, e_exc_ack, e_save_if, e_save_id, e_save_cause, e_mret;
  pc_sel_e e_mux;
  exc_pc_sel_e e_exc_mux;
  logic [cause_w-1:0] e_cause;
  logic [xlen-1:0] e_mtval;

  // stimulus modes
  bit in_reset, quiet, fetch_on, wfi_once, wake_irq;
  int error_count, n_traps, n_irqs, n_sleeps, n_jumps;

  assign cause_bits = exc_cause_o;

  core_ctrl u_core_ctrl (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////

  task automatic abort_run(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // cycle model
  ////////////////////////////////////////

  task automatic model_eval();
    logic stall, special, trap_pend, hirq, halt_if, halt_id;
    model_state_e nxt;
    stall     = stall_lsu_i | stall_multdiv_i | stall_jump_i | stall_branch_i;
    // raw LSU faults request a flush, registered ones decide the trap
    special   = mret_insn_i | wfi_insn_i | csr_status_i | illegal_insn_i | ecall_insn_i |
                ebrk_insn_i | load_err_i | store_err_i;
    trap_pend = illegal_insn_i | ecall_insn_i | ebrk_insn_i | m_load_q | m_store_q;
    hirq      = irq_req_ctrl_i & m_ie_i;
    {e_first, e_set, halt_if, halt_id, e_irq_ack, e_exc_ack} = '0;
    {e_save_if, e_save_id, e_save_cause, e_mret} = '0;
    e_busy    = 1'b1;
    e_req     = 1'b1;
    e_mux     = PC_BOOT;
    e_exc_mux = EXC_PC_EXC;
    e_cause   = EXC_CAUSE_NONE;
    e_mtval   = '0;
    nxt       = m_state;
    case (m_state)
      S_RESET: begin
        e_req = 1'b0;
        e_set = 1'b1;
        if (fetch_enable_i) nxt = S_BOOT_SET;
      end
      S_BOOT_SET: begin
        e_set = 1'b1;
        nxt   = S_FIRST_FETCH;
      end
      S_FIRST_FETCH: begin
        e_first = 1'b1;
        if (hirq) begin
          {halt_if, halt_id} = 2'b11;
          nxt = S_IRQ_TAKEN;
        end else if (!stall) begin
          nxt = S_DECODE;
        end
      end
      S_DECODE: begin
        if (instr_valid_i && (branch_set_i || jump_set_i)) begin
          e_set = 1'b1;
          e_mux = PC_JUMP;
          n_jumps++;
        end else if (instr_valid_i && special) begin
          {halt_if, halt_id} = 2'b11;
          nxt = S_FLUSH;
        end
        // pending irq behind a multicycle instr only blocks IF
        if (hirq && stall) halt_if = 1'b1;
        if (hirq && !stall && !special) begin
          {halt_if, halt_id} = 2'b11;
          nxt = S_IRQ_TAKEN;
        end
      end
      S_FLUSH: begin
        {halt_if, halt_id} = 2'b11;
        nxt = S_DECODE;
        if (trap_pend) begin
          e_set     = 1'b1;
          e_mux     = PC_EXC;
          e_exc_mux = EXC_PC_EXC;
          {e_save_id, e_save_cause} = 2'b11;
          n_traps++;
          // illegal, ecall, ebreak, store fault, load fault
          if (illegal_insn_i) begin
            e_cause = 6'd2;
            e_mtval = instr_is_compressed_i ? {16'h0000, instr_compressed_i} : instr_i;
          end else if (ecall_insn_i) begin
            e_cause = 6'd11;
          end else if (ebrk_insn_i) begin
            e_cause = 6'd3;
          end else if (m_store_q) begin
            e_cause = 6'd7;
            e_mtval = lsu_addr_last_i;
          end else begin
            e_cause = 6'd5;
            e_mtval = lsu_addr_last_i;
          end
        end else if (mret_insn_i) begin
          e_set  = 1'b1;
          e_mux  = PC_ERET;
          e_mret = 1'b1;
        end else if (wfi_insn_i) begin
          nxt = S_WAIT_SLEEP;
          n_sleeps++;
        end
      end
      S_IRQ_TAKEN: begin
        e_set     = 1'b1;
        e_mux     = PC_EXC;
        e_exc_mux = EXC_PC_IRQ;
        {e_save_if, e_save_cause, e_irq_ack, e_exc_ack} = 4'b1111;
        e_cause   = {1'b1, irq_id_ctrl_i};
        nxt       = S_DECODE;
        n_irqs++;
      end
      default: begin
        // wait for sleep and sleep
        {e_busy, e_req} = 2'b00;
        {halt_if, halt_id} = 2'b11;
        if (m_state == S_WAIT_SLEEP) nxt = S_SLEEP;
        else if (irq_i) nxt = S_FIRST_FETCH;
      end
    endcase
    e_ready   = !stall && !halt_if;
    e_clear   = !stall || halt_id;
    m_state_d = rst_ni ? nxt : S_RESET;
    m_load_d  = rst_ni & load_err_i;
    m_store_d = rst_ni & store_err_i;
  endtask

  task automatic compare_outputs();
    check_value("ctrl_busy_o", 32'(ctrl_busy_o), 32'(e_busy));
    check_value("first_fetch_o", 32'(first_fetch_o), 32'(e_first));
    check_value("instr_req_o", 32'(instr_req_o), 32'(e_req));
    check_value("pc_set_o", 32'(pc_set_o), 32'(e_set));
    if (e_set) check_value("pc_mux_o", 32'(pc_mux_o), 32'(e_mux));
    if (e_set && e_mux == PC_EXC) check_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(e_exc_mux));
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'(e_ready));
    check_value("instr_valid_clear_o", 32'(instr_valid_clear_o), 32'(e_clear));
    check_value("irq_ack_o", 32'(irq_ack_o), 32'(e_irq_ack));
    check_value("exc_ack_o", 32'(exc_ack_o), 32'(e_exc_ack));
    if (e_irq_ack) check_value("irq_id_o", 32'(irq_id_o), 32'(irq_id_ctrl_i));
    check_value("csr_save_if_o", 32'(csr_save_if_o), 32'(e_save_if));
    check_value("csr_save_id_o", 32'(csr_save_id_o), 32'(e_save_id));
    check_value("csr_save_cause_o", 32'(csr_save_cause_o), 32'(e_save_cause));
    check_value("csr_restore_mret_o", 32'(csr_restore_mret_o), 32'(e_mret));
    check_value("exc_cause_o", 32'(cause_bits), 32'(e_cause));
    check_value("csr_mtval_o", csr_mtval_o, e_mtval);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_inputs();
    logic [31:0] r, s, w, a;
    r = $urandom();
    s = $urandom();
    w = $urandom();
    a = $urandom();
    rst_ni         <= !in_reset;
    fetch_enable_i <= fetch_on;
    // decoder side stays put while the instr sits in FLUSH
    if (m_state != S_FLUSH) begin
      {instr_valid_i, branch_set_i, jump_set_i, illegal_insn_i, ecall_insn_i} <= '0;
      {ebrk_insn_i, mret_insn_i, wfi_insn_i, csr_status_i} <= '0;
      instr_i               <= w;
      instr_compressed_i    <= a[31:16];
      instr_is_compressed_i <= r[29];
      if (wfi_once && m_state == S_DECODE) begin
        instr_valid_i <= 1'b1;
        wfi_insn_i    <= 1'b1;
        wfi_once       = 1'b0;
      end else if (!quiet) begin
        instr_valid_i <= r[1:0] != 2'd0;
        case (r[5:2])
          4'd6:  branch_set_i   <= 1'b1;
          4'd7:  jump_set_i     <= 1'b1;
          4'd8:  illegal_insn_i <= 1'b1;
          4'd9:  ecall_insn_i   <= 1'b1;
          4'd10: ebrk_insn_i    <= 1'b1;
          4'd11: mret_insn_i    <= 1'b1;
          4'd12: wfi_insn_i     <= 1'b1;
          4'd13: csr_status_i   <= 1'b1;
          4'd14: begin
            // mixed exception flags for the priority check
            illegal_insn_i <= r[6];
            ecall_insn_i   <= r[7];
            ebrk_insn_i    <= r[8];
          end
          default: ;
        endcase
      end
    end
    // lsu faults are single cycle pulses
    load_err_i      <= !quiet && m_state != S_FLUSH && r[12:9] == 4'd0;
    store_err_i     <= !quiet && m_state != S_FLUSH && r[16:13] == 4'd0;
    lsu_addr_last_i <= a;
    stall_lsu_i     <= !quiet && s[2:0] == 3'd0;
    stall_multdiv_i <= quiet ? s[3] : s[5:3] == 3'd0;
    stall_jump_i    <= !quiet && s[8:6] == 3'd0;
    stall_branch_i  <= !quiet && s[11:9] == 3'd0;
    irq_req_ctrl_i  <= !quiet && s[14:12] == 3'd0;
    m_ie_i          <= !quiet && s[15];
    irq_id_ctrl_i   <= s[20:16];
    irq_i           <= quiet ? wake_irq : s[23:21] == 3'd0;
  endtask

  // drive on the rising edge, check on the falling edge
  task automatic run_cycle();
    @(posedge clk_i);
    m_state   = m_state_d;
    m_load_q  = m_load_d;
    m_store_q = m_store_d;
    drive_inputs();
    @(negedge clk_i);
    model_eval();
    compare_outputs();
  endtask

  task automatic wait_boot_done(input int limit);
    bit done;
    done = 1'b0;
    for (int n = 0; n < limit && !done; n++) begin
      run_cycle();
      done = first_fetch_o && id_in_ready_o;
    end
    if (!done) abort_run("timeout: first fetch never completed after boot");
  endtask

  task automatic wait_busy(input logic level, input int limit, input string what);
    bit done;
    done = 1'b0;
    for (int n = 0; n < limit && !done; n++) begin
      run_cycle();
      done = ctrl_busy_o == level;
    end
    if (!done) abort_run($sformatf("timeout waiting for %s", what));
  endtask

  initial begin
    void'($urandom(32'hc6ba_55a7));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    fetch_enable_i = 1'b0;
    {illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, wfi_insn_i, csr_status_i} = '0;
    {instr_valid_i, instr_is_compressed_i, branch_set_i, jump_set_i} = '0;
    instr_i = '0;
    instr_compressed_i = '0;
    lsu_addr_last_i = '0;
    {load_err_i, store_err_i, irq_i, irq_req_ctrl_i, m_ie_i} = '0;
    irq_id_ctrl_i = '0;
    {stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i} = '0;
    m_state_d = S_RESET;
    {m_load_d, m_store_d} = 2'b00;
    {in_reset, quiet, fetch_on, wfi_once, wake_irq} = 5'b11000;

    repeat (10) run_cycle();
    in_reset = 1'b0;
    // boot address held while fetch is disabled
    repeat (3) run_cycle();
    fetch_on = 1'b1;
    wait_boot_done(40);

    // wfi then sleep until the irq line rises
    wfi_once = 1'b1;
    wait_busy(1'b0, 10, "sleep entry after wfi");
    repeat (5) run_cycle();
    wake_irq = 1'b1;
    wait_busy(1'b1, 10, "wake from sleep");
    wake_irq = 1'b0;

    quiet = 1'b0;
    repeat (4000) run_cycle();

    $display("jumps %0d traps %0d irqs %0d sleeps %0d", n_jumps, n_traps, n_irqs, n_sleeps);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
core_ctrl_pkg.sv
ctrl_req_decode.sv
ctrl_fsm.sv
ctrl_trap_result.sv
core_ctrl.sv
core_ctrl_asserts.sv
tb_core_ctrl.sv
